//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= command_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
+incdir+sim
verilog/command_pkg.sv
verilog/command_buffer.sv
verilog/command_arbiter.sv
verilog/command_control.sv
verilog/command.sv
sim/command_tb.sv

//--- sim/command_model.svh
// Buffer depths in class order: read, write, wed, restart.
localparam int DEPTHS [4] = '{32, 32, 2, 2};
localparam int MARGIN = 2;

// Accepted commands per class, oldest first.
command_buffer_line expected_q [4][$];
int model_count [4] = '{0, 0, 0, 0};
int model_credits = 0;
int expected_tag = 0;
int issued = 0;
int dropped = 0;
int checks = 0;
int errors = 0;

task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
	checks++;
	assert (got === want) else begin
		$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, want);
		errors++;
	end
endtask

task automatic report_fault(input string what);
	$display("ERROR at %0t: %s", $time, what);
	errors++;
endtask

// A command seen on the host interface must be the oldest one of its class.
task automatic check_issue(input command_interface_output seen);
	command_buffer_line want;
	int c;
	c = int'(seen.cmd_class);
	issued++;
	assert (expected_q[c].size() > 0) else report_fault("command issued with nothing pending");
	if (expected_q[c].size() > 0) begin
		want = expected_q[c].pop_front();
		compare("command_out.command", 64'(seen.command), 64'(want.command));
		compare("command_out.address", seen.address, want.address);
		compare("command_out.size", 64'(seen.size), 64'(want.size));
	end
	compare("command_out.tag", 64'(seen.tag), 64'(expected_tag % 256));
	expected_tag++;
endtask

// Host credit count across one clock edge.
task automatic credit_step(input logic rise, input logic [7:0] room, input logic issue,
		input response_interface resp);
	if (rise) begin
		model_credits = int'(room);
	end
	if (issue) begin
		assert (model_credits > 0) else report_fault("command issued without a credit");
		model_credits--;
	end
	if (resp.valid) begin
		model_credits += int'(resp.credits);
	end
endtask

// Buffer occupancy across one clock edge. A push into a full buffer is lost.
task automatic buffer_step(input int c, input command_buffer_line line, input logic popped,
		input buffer_status seen);
	buffer_status want;
	if (line.valid) begin
		if (model_count[c] < DEPTHS[c]) begin
			expected_q[c].push_back(line);
			model_count[c]++;
		end else begin
			dropped++;
		end
	end
	if (popped) begin
		model_count[c]--;
	end
	want.full = (model_count[c] == DEPTHS[c]);
	want.alfull = (model_count[c] >= DEPTHS[c] - MARGIN);
	want.empty = (model_count[c] == 0);
	want.valid = !want.empty;
	compare($sformatf("status of buffer %0d", c), 64'(seen), 64'(want));
endtask

function automatic int pending();
	int total;
	total = 0;
	for (int c = 0; c < 4; c++) begin
		total += expected_q[c].size();
	end
	return total;
endfunction

//--- sim/command_tb.sv
`timescale 1ns/10ps

module command_tb
	import command_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int FILL_CYCLES = 36;
	localparam int QUIET_CYCLES = 20;
	localparam int RANDOM_CYCLES = 600;
	localparam int DRAIN_CYCLES = 100;
	localparam int CYCLE_LIMIT = RESET_CYCLES + FILL_CYCLES + 6 * QUIET_CYCLES
		+ RANDOM_CYCLES + 2 * DRAIN_CYCLES + 100;

	logic                    clock;
	logic                    rst_n;
	logic                    enabled;
	command_buffer_line      line_in [4];
	command_interface_input  command_in;
	response_interface       response;
	command_interface_output command_out;
	command_buffer_status    buffer_status_out;

	// Inputs as the DUT took them at the last edge and at the edge before.
	command_buffer_line   edge_line [4];
	command_buffer_line   prev_line [4];
	logic                 edge_enabled;
	logic                 prev_enabled;
	logic [7:0]           edge_room;
	response_interface    edge_response;
	command_buffer_status status_prev;
	logic                 monitor_on = 1'b0;
	logic [31:0]          lcg_state = 32'd41817;
	int                   cycle_count = 0;

	`include "command_model.svh"

	command uut (
		.clock                 (clock),
		.rst_n                 (rst_n),
		.enabled               (enabled),
		.read_command_in       (line_in[0]),
		.write_command_in      (line_in[1]),
		.wed_command_in        (line_in[2]),
		.restart_command_in    (line_in[3]),
		.command_in            (command_in),
		.response              (response),
		.command_out           (command_out),
		.command_buffer_status (buffer_status_out)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, %0d commands never issued", cycle_count, pending());
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	always @(posedge clock) begin
		edge_line <= line_in;
		prev_line <= edge_line;
		edge_enabled <= enabled;
		prev_enabled <= edge_enabled;
		edge_room <= command_in.room;
		edge_response <= response;
	end

	// A pop is only known one cycle later from command_out, so buffers are
	// checked one edge behind the credits.
	always @(negedge clock) begin : monitor
		int popped_class;
		if (monitor_on) begin
			popped_class = -1;
			if (command_out.valid) begin
				check_issue(command_out);
				popped_class = int'(command_out.cmd_class);
			end
			credit_step(edge_enabled & ~prev_enabled, edge_room, command_out.valid, edge_response);
			for (int c = 0; c < 4; c++) begin
				buffer_step(c, prev_line[c], popped_class == c, status_of(status_prev, c));
			end
		end
		status_prev = buffer_status_out;
	end

	function automatic buffer_status status_of(input command_buffer_status s, input int c);
		buffer_status all [4];
		all = '{s.read_buffer, s.write_buffer, s.wed_buffer, s.restart_buffer};
		return all[c];
	endfunction

	// Upper bits only, since the low bits of this generator cycle quickly.
	function automatic logic [31:0] lcg();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	function automatic bit chance(input int n);
		return (lcg() % 32'(n)) == 32'd0;
	endfunction

	function automatic command_buffer_line make_line(input int c);
		command_buffer_line line;
		logic [31:0] r;
		r = lcg();
		line.valid = 1'b1;
		line.cmd_class = command_class'(c[1:0]);
		line.address = {lcg(), lcg()};
		line.size = r[11:0];
		line.engine_id = r[19:12];
		case (c)
			0:       line.command = r[20] ? read_cl_na : read_cl_s;
			1:       line.command = r[20] ? write_na : write_mi;
			2:       line.command = read_pna;
			default: line.command = restart_op;
		endcase
		return line;
	endfunction

	// Moves to 1 ns after the next rising edge and drops all strobes.
	task automatic step();
		@(posedge clock);
		#1;
		for (int c = 0; c < 4; c++) begin
			line_in[c].valid = 1'b0;
		end
		response.valid = 1'b0;
	endtask

	task automatic wait_issued(input int target);
		while (issued < target) begin
			step();
		end
	endtask

	task automatic return_credits(input int amount);
		response.valid = 1'b1;
		response.credits = 8'(amount);
		step();
	endtask

	// The model sees a push two edges after it is driven.
	task automatic drain();
		repeat (3) step();
		while (pending() > 0) begin
			step();
		end
		repeat (2) step();
	endtask

	task automatic finish_test(input string name, input int errors_before);
		$display("Test %s done with %0d errors", name, errors - errors_before);
	endtask

	initial begin
		int mark;
		int base;
		rst_n = 1'b0;
		enabled = 1'b0;
		command_in = '0;
		response = '0;
		for (int c = 0; c < 4; c++) begin
			line_in[c] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rst_n = 1'b1;
		repeat (2) step();
		monitor_on = 1'b1;

		// Every buffer is pushed past full while the port is disabled.
		mark = errors;
		repeat (FILL_CYCLES) begin
			step();
			for (int c = 0; c < 4; c++) begin
				line_in[c] = make_line(c);
			end
		end
		repeat (QUIET_CYCLES) step();
		compare("issue count", 64'(issued), 64'd0);
		finish_test("disabled port", mark);

		mark = errors;
		command_in.room = 8'd5;
		enabled = 1'b1;
		wait_issued(5);
		repeat (QUIET_CYCLES) step();
		compare("issue count", 64'(issued), 64'd5);
		return_credits(3);
		wait_issued(8);
		repeat (QUIET_CYCLES) step();
		compare("issue count", 64'(issued), 64'd8);
		finish_test("credit limit", mark);

		mark = errors;
		return_credits(100);
		drain();
		finish_test("ordered drain", mark);

		// Credits are left over here, so only enabled holds the commands back.
		mark = errors;
		enabled = 1'b0;
		base = issued;
		repeat (2) begin
			step();
			for (int c = 0; c < 4; c++) begin
				line_in[c] = make_line(c);
			end
		end
		repeat (QUIET_CYCLES) step();
		compare("issue count", 64'(issued), 64'(base));
		// The credit count restarts from room rather than adding to it.
		command_in.room = 8'd3;
		enabled = 1'b1;
		wait_issued(base + 3);
		repeat (QUIET_CYCLES) step();
		compare("issue count", 64'(issued), 64'(base + 3));
		finish_test("disable and reload", mark);

		mark = errors;
		repeat (RANDOM_CYCLES) begin
			step();
			for (int c = 0; c < 4; c++) begin
				if (chance(4)) begin
					line_in[c] = make_line(c);
				end
			end
			if (model_credits < 50 && chance(3)) begin
				response.valid = 1'b1;
				response.credits = 8'(1 + (lcg() % 3));
			end
		end
		step();
		return_credits(100);
		drain();
		assert (issued > 256) else report_fault("too few commands to wrap the tag counter");
		finish_test("random traffic", mark);

		$display("Summary: %0d checks, %0d errors, %0d issued, %0d pushes dropped",
			checks, errors, issued, dropped);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/command.sv
`timescale 1ns/10ps

module command
	import command_pkg::*;
#(
	parameter int READ_DEPTH = 32,
	parameter int WRITE_DEPTH = 32,
	parameter int WED_DEPTH = 2,
	parameter int RESTART_DEPTH = 2,
	parameter int ALFULL_MARGIN = 2
) (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic                               enabled,
	input  command_buffer_line                 read_command_in,
	input  command_buffer_line                 write_command_in,
	input  command_buffer_line                 wed_command_in,
	input  command_buffer_line                 restart_command_in,
	input  command_interface_input             command_in,
	input  response_interface                  response,
	output command_interface_output            command_out,
	output command_pkg::command_buffer_status  command_buffer_status
);

	command_buffer_line read_head;
	command_buffer_line write_head;
	command_buffer_line wed_head;
	command_buffer_line restart_head;
	command_buffer_line arbiter_line;
	arbiter_request     request;
	arbiter_ready       ready;
	logic               issue_allowed;

	// Any buffer holding a command asks for the host port.
	assign request.read_request    = ~command_buffer_status.read_buffer.empty;
	assign request.write_request   = ~command_buffer_status.write_buffer.empty;
	assign request.wed_request     = ~command_buffer_status.wed_buffer.empty;
	assign request.restart_request = ~command_buffer_status.restart_buffer.empty;

	command_buffer #(.DEPTH(READ_DEPTH), .ALFULL_MARGIN(ALFULL_MARGIN)) read_buffer (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (read_command_in.valid),
		.data_in  (read_command_in),
		.pop      (ready.read_ready),
		.data_out (read_head),
		.status   (command_buffer_status.read_buffer)
	);

	command_buffer #(.DEPTH(WRITE_DEPTH), .ALFULL_MARGIN(ALFULL_MARGIN)) write_buffer (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (write_command_in.valid),
		.data_in  (write_command_in),
		.pop      (ready.write_ready),
		.data_out (write_head),
		.status   (command_buffer_status.write_buffer)
	);

	command_buffer #(.DEPTH(WED_DEPTH), .ALFULL_MARGIN(ALFULL_MARGIN)) wed_buffer (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (wed_command_in.valid),
		.data_in  (wed_command_in),
		.pop      (ready.wed_ready),
		.data_out (wed_head),
		.status   (command_buffer_status.wed_buffer)
	);

	command_buffer #(.DEPTH(RESTART_DEPTH), .ALFULL_MARGIN(ALFULL_MARGIN)) restart_buffer (
		.clock    (clock),
		.rst_n    (rst_n),
		.push     (restart_command_in.valid),
		.data_in  (restart_command_in),
		.pop      (ready.restart_ready),
		.data_out (restart_head),
		.status   (command_buffer_status.restart_buffer)
	);

	command_arbiter arbiter (
		.clock         (clock),
		.rst_n         (rst_n),
		.request       (request),
		.issue_allowed (issue_allowed),
		.read_line     (read_head),
		.write_line    (write_head),
		.wed_line      (wed_head),
		.restart_line  (restart_head),
		.ready         (ready),
		.arbiter_line  (arbiter_line)
	);

	command_control control (
		.clock         (clock),
		.rst_n         (rst_n),
		.enabled       (enabled),
		.command_in    (command_in),
		.arbiter_line  (arbiter_line),
		.response      (response),
		.issue_allowed (issue_allowed),
		.command_out   (command_out)
	);

endmodule

//--- verilog/command_arbiter.sv
`timescale 1ns/10ps

module command_arbiter
	import command_pkg::*;
(
	input  logic               clock,
	input  logic               rst_n,
	input  arbiter_request     request,
	input  logic               issue_allowed,
	input  command_buffer_line read_line,
	input  command_buffer_line write_line,
	input  command_buffer_line wed_line,
	input  command_buffer_line restart_line,
	output arbiter_ready       ready,
	output command_buffer_line arbiter_line
);

	localparam int CLASSES = 4;

	// Bit and line index follow the command_class encoding.
	logic [CLASSES-1:0] request_bits;
	command_buffer_line lines [CLASSES];

	logic [1:0] last_grant;
	logic [1:0] grant_index;
	logic       grant_found;
	logic       grant;

	assign request_bits[read]    = request.read_request;
	assign request_bits[write]   = request.write_request;
	assign request_bits[wed]     = request.wed_request;
	assign request_bits[restart] = request.restart_request;

	assign lines[read]    = read_line;
	assign lines[write]   = write_line;
	assign lines[wed]     = wed_line;
	assign lines[restart] = restart_line;

	// Search starts one past the last winner and wraps, so the last winner
	// is looked at only when nobody else is asking.
	always_comb begin : select_winner
		logic [1:0] candidate;
		grant_found = 1'b0;
		grant_index = last_grant;
		for (int i = 1; i <= CLASSES; i++) begin
			candidate = last_grant + 2'(i);
			if (!grant_found && request_bits[candidate]) begin
				grant_found = 1'b1;
				grant_index = candidate;
			end
		end
	end

	// Nothing leaves a buffer unless the control has a credit for it.
	assign grant = grant_found & issue_allowed;

	always_comb begin
		ready               = '0;
		ready.read_ready    = grant && (grant_index == read);
		ready.write_ready   = grant && (grant_index == write);
		ready.wed_ready     = grant && (grant_index == wed);
		ready.restart_ready = grant && (grant_index == restart);
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			// Read gets the first turn after reset.
			last_grant         <= 2'(restart);
			arbiter_line.valid <= 1'b0;
		end else begin
			arbiter_line.valid <= grant;
			if (grant) begin
				last_grant             <= grant_index;
				arbiter_line.command   <= lines[grant_index].command;
				arbiter_line.address   <= lines[grant_index].address;
				arbiter_line.size      <= lines[grant_index].size;
				arbiter_line.cmd_class <= lines[grant_index].cmd_class;
				arbiter_line.engine_id <= lines[grant_index].engine_id;
			end
		end
	end

endmodule

//--- verilog/command_buffer.sv
`timescale 1ns/10ps

module command_buffer
	import command_pkg::*;
#(
	parameter int DEPTH = 32,
	parameter int ALFULL_MARGIN = 2
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               push,
	input  command_buffer_line data_in,
	input  logic               pop,
	output command_buffer_line data_out,
	output buffer_status       status
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);
	// Occupancy at which the almost-full flag comes up.
	localparam int ALFULL_LEVEL = (DEPTH > ALFULL_MARGIN) ? DEPTH - ALFULL_MARGIN : 0;

	command_buffer_line memory [DEPTH];

	logic [PTR_W-1:0]   write_ptr;
	logic [PTR_W-1:0]   read_ptr;
	logic [COUNT_W-1:0] count;
	logic               full;
	logic               empty;
	logic               do_push;
	logic               do_pop;

	assign full  = (count == COUNT_W'(DEPTH));
	assign empty = (count == '0);

	// A push into a full buffer is lost. A pop of an empty one does nothing.
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			memory[write_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			write_ptr <= '0;
			read_ptr  <= '0;
			count     <= '0;
		end else begin
			if (do_push) begin
				write_ptr <= (write_ptr == PTR_W'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
			end
			if (do_pop) begin
				read_ptr <= (read_ptr == PTR_W'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The head is shown as soon as it is written, so the arbiter can take it
	// in the same cycle it pops.
	always_comb begin
		data_out       = memory[read_ptr];
		data_out.valid = memory[read_ptr].valid & ~empty;
	end

	assign status.full   = full;
	assign status.alfull = (int'(count) >= ALFULL_LEVEL);
	assign status.valid  = ~empty;
	assign status.empty  = empty;

endmodule

//--- verilog/command_control.sv
`timescale 1ns/10ps

module command_control
	import command_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    enabled,
	input  command_interface_input  command_in,
	input  command_buffer_line      arbiter_line,
	input  response_interface       response,
	output logic                    issue_allowed,
	output command_interface_output command_out
);

	logic       enabled_q;
	logic       enabled_rise;
	logic       issue;
	logic [7:0] in_flight;
	logic [7:0] credits;
	logic [7:0] credit_base;
	logic [7:0] credit_return;
	logic [7:0] tag_count;

	assign enabled_rise = enabled & ~enabled_q;

	// A valid line from the arbiter always goes out on the next edge.
	// Its credit was checked when it was popped.
	assign issue = arbiter_line.valid;

	// At most one line sits between pop and issue, and its credit is
	// still counted in credits until it goes out.
	assign in_flight = {7'd0, arbiter_line.valid};

	assign issue_allowed = enabled && (credits > in_flight);

	// The host grants a fresh credit limit each time the port is enabled.
	assign credit_base   = enabled_rise ? command_in.room : credits;
	assign credit_return = response.valid ? response.credits : 8'd0;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			enabled_q <= 1'b0;
		end else begin
			enabled_q <= enabled;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			credits <= 8'd0;
		end else begin
			credits <= credit_base - {7'd0, issue} + credit_return;
		end
	end

	// Tags are handed out in issue order and wrap at 256.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tag_count <= 8'd0;
		end else if (issue) begin
			tag_count <= tag_count + 8'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			command_out.valid <= 1'b0;
		end else begin
			command_out.valid <= issue;
			if (issue) begin
				command_out.command   <= arbiter_line.command;
				command_out.address   <= arbiter_line.address;
				command_out.size      <= arbiter_line.size;
				command_out.cmd_class <= arbiter_line.cmd_class;
				command_out.tag       <= tag_count;
			end
		end
	end

endmodule

//--- verilog/command_pkg.sv
package command_pkg;

	// Host command codes. The class of a command decides which buffer it
	// waits in, not the code itself.
	typedef enum logic [7:0] {
		no_command = 8'h00,
		restart_op = 8'h01,
		read_cl_na = 8'h0a,
		write_na   = 8'h0d,
		read_pna   = 8'h0e,
		read_cl_s  = 8'h5a,
		read_cl_m  = 8'h6a,
		write_mi   = 8'h6d,
		write_ms   = 8'h7d
	} command_type;

	// The order also sets the round-robin order of the arbiter.
	typedef enum logic [1:0] {
		read    = 2'd0,
		write   = 2'd1,
		wed     = 2'd2,
		restart = 2'd3
	} command_class;

	// One command line as handed over by an engine.
	// The valid bit doubles as the push strobe into its buffer.
	typedef struct packed {
		logic         valid;
		command_type  command;
		logic [63:0]  address;
		logic [11:0]  size;
		command_class cmd_class;
		logic [7:0]   engine_id;
	} command_buffer_line;

	typedef struct packed {
		logic full;
		logic alfull;
		logic valid;
		logic empty;
	} buffer_status;

	typedef struct packed {
		buffer_status read_buffer;
		buffer_status write_buffer;
		buffer_status wed_buffer;
		buffer_status restart_buffer;
	} command_buffer_status;

	typedef struct packed {
		logic read_request;
		logic write_request;
		logic wed_request;
		logic restart_request;
	} arbiter_request;

	// One pop strobe per buffer; at most one is high in a cycle.
	typedef struct packed {
		logic read_ready;
		logic write_ready;
		logic wed_ready;
		logic restart_ready;
	} arbiter_ready;

	typedef struct packed {
		logic [7:0] room;
	} command_interface_input;

	typedef struct packed {
		logic         valid;
		command_type  command;
		logic [63:0]  address;
		logic [11:0]  size;
		logic [7:0]   tag;
		command_class cmd_class;
	} command_interface_output;

	typedef struct packed {
		logic       valid;
		logic [7:0] tag;
		logic [7:0] credits;
	} response_interface;

endpackage
